// ==== hdl/gfx_pkg.sv ====
// drawing types shared by the scene sequencer and the rasterizer
// coordinates are signed so shapes may start off screen
package gfx_pkg;

    localparam int CORDW = 16;  // coordinate width
    localparam int CIDXW = 4;   // colour index width

    typedef logic signed [CORDW-1:0] coord_t;
    typedef logic [CIDXW-1:0] cidx_t;

    // drawing command opcodes
    typedef enum logic {
        OP_CLEAR,  // whole framebuffer to colour 0
        OP_RECT    // filled rectangle, inclusive corners
    } draw_op_e;

    // scene sequencer states
    typedef enum logic [2:0] {
        IDLE, CLEAR, INIT, DRAW, DONE
    } seq_state_e;

endpackage

// ==== hdl/fb_pkg.sv ====
// framebuffer geometry and addressing
package fb_pkg;

    localparam int FB_WIDTH  = 32;                    // pixels per row
    localparam int FB_HEIGHT = 16;                    // rows
    localparam int FB_DEPTH  = FB_WIDTH * FB_HEIGHT;  // 512 entries
    localparam int FB_ADDRW  = $clog2(FB_DEPTH);

    typedef logic [FB_ADDRW-1:0] fb_addr_t;

    // row-major word address, y * width + x
    function automatic fb_addr_t fb_addr(input int x, input int y);
        return fb_addr_t'(y * FB_WIDTH + x);
    endfunction

endpackage

// ==== hdl/draw_cmd_if.sv ====
// drawing command channel, sequencer to rasterizer
// valid/ready handshake, payload held from valid until transfer
`timescale 1ns/1ps

interface draw_cmd_if;
    import gfx_pkg::*;

    logic     valid;
    logic     ready;     // high only while rasterizer idle
    draw_op_e op;
    coord_t   x0, y0;    // first corner
    coord_t   x1, y1;    // opposite corner, inclusive
    cidx_t    cidx;      // fill colour, ignored for clear

    modport seq (
        output valid, op, x0, y0, x1, y1, cidx,
        input  ready
    );

    modport raster (
        input  valid, op, x0, y0, x1, y1, cidx,
        output ready
    );
endinterface

// ==== hdl/fb_pix_if.sv ====
// pixel write channel, rasterizer to framebuffer
`timescale 1ns/1ps

interface fb_pix_if;
    import gfx_pkg::*;

    logic   valid;
    logic   ready;  // low while a read owns the store
    coord_t x, y;   // always inside the framebuffer
    cidx_t  cidx;

    modport raster (
        output valid, x, y, cidx,
        input  ready
    );

    modport fb (
        input  valid, x, y, cidx,
        output ready
    );
endinterface

// ==== hdl/rect_scene_seq.sv ====
// scene sequencer: one clear then SHAPE_CNT offset rectangles
// paces the rasterizer with a frame wait and a per-frame cycle budget
`timescale 1ns/1ps

module rect_scene_seq #(
    parameter int SHAPE_CNT     = 6,   // rectangles per scene
    parameter int FRAME_WAIT    = 2,   // frames held off after start
    parameter int CYC_PER_FRAME = 64   // step cycles granted per frame
) (
    input  logic    clk_100m,
    input  logic    arst_n,
    input  logic    frame,     // one-cycle frame strobe
    input  logic    start,
    draw_cmd_if.seq cmd,
    output logic    step_en,
    output logic    busy,
    output logic    done
);
    import gfx_pkg::*;

    localparam int IDW = $clog2(SHAPE_CNT + 1);
    localparam int FWW = $clog2(FRAME_WAIT + 2);
    localparam int CPW = $clog2(CYC_PER_FRAME + 2);

    seq_state_e     state;
    logic [IDW-1:0] shape_id;   // shape being drawn
    logic [IDW-1:0] next_id;    // shape for the next command
    logic [FWW-1:0] wait_cnt;   // frame strobes since start
    logic [CPW-1:0] budget;     // step cycles left this frame
    logic           launch;
    logic           wait_over;

    assign launch    = start && (state == IDLE || state == DONE);
    assign wait_over = (wait_cnt == FWW'(FRAME_WAIT));
    assign next_id   = (cmd.op == OP_CLEAR) ? '0 : shape_id + 1'b1;  // clear precedes shape 0
    assign step_en   = busy && (budget != '0);

    always_ff @(posedge clk_100m or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            shape_id  <= '0;
            cmd.valid <= 1'b0;
            cmd.op    <= OP_CLEAR;
            busy      <= 1'b0;
            done      <= 1'b0;
        end else begin
            case (state)
                CLEAR, INIT: if (cmd.ready) begin  // valid is up, transfer now
                    cmd.valid <= 1'b0;
                    state     <= DRAW;
                end
                DRAW: if (cmd.ready) begin  // rasterizer finished last command
                    if (cmd.op == OP_RECT && shape_id == IDW'(SHAPE_CNT - 1)) begin
                        state <= DONE;
                        busy  <= 1'b0;
                        done  <= 1'b1;
                    end else begin
                        shape_id  <= next_id;
                        cmd.op    <= OP_RECT;
                        cmd.valid <= 1'b1;
                        state     <= INIT;
                    end
                end
                default: if (launch) begin  // IDLE or DONE
                    cmd.op    <= OP_CLEAR;
                    cmd.valid <= 1'b1;
                    busy      <= 1'b1;
                    done      <= 1'b0;
                    state     <= CLEAR;
                end
            endcase
        end
    end

    // shape geometry, loaded as the next rectangle is issued
    always_ff @(posedge clk_100m) begin
        if (state == DRAW && cmd.ready) begin
            cmd.x0   <= coord_t'(2 + 2 * next_id);
            cmd.y0   <= coord_t'(1 + next_id);
            cmd.x1   <= coord_t'(12 + 2 * next_id);
            cmd.y1   <= coord_t'(8 + next_id);
            cmd.cidx <= cidx_t'(next_id + 1);  // colour 0 is background
        end
    end

    // frame wait then per-frame budget
    always_ff @(posedge clk_100m or negedge arst_n) begin
        if (!arst_n) begin
            wait_cnt <= '0;
            budget   <= '0;
        end else if (launch) begin
            wait_cnt <= '0;
            budget   <= '0;
        end else if (frame && busy) begin
            if (!wait_over) wait_cnt <= wait_cnt + 1'b1;  // still holding off
            else budget <= CPW'(CYC_PER_FRAME);          // refill each frame
        end else if (budget != '0) begin
            budget <= budget - 1'b1;  // stalls spend budget too
        end
    end

    // rasterizer relies on a steady command while it is busy
    a_cmd_hold: assert property (@(posedge clk_100m) disable iff (!arst_n)
        cmd.valid && !cmd.ready |=> cmd.valid
            && $stable({cmd.op, cmd.x0, cmd.y0, cmd.x1, cmd.y1, cmd.cidx}));

endmodule

// ==== hdl/rect_fill_raster.sv ====
// filled rectangle rasterizer, x inside y over inclusive corners
// off-screen pixels are skipped so oversized shapes still finish
`timescale 1ns/1ps

module rect_fill_raster (
    input  logic       clk_100m,
    input  logic       arst_n,
    draw_cmd_if.raster cmd,
    input  logic       step_en,  // pacing from the sequencer
    fb_pix_if.raster   pix
);
    import gfx_pkg::*;
    import fb_pkg::*;

    logic   active;          // walking a rectangle
    logic   held;            // offered pixel still waiting
    coord_t cx, cy;          // scan position
    coord_t bx0, bx1, by1;   // latched bounds
    coord_t lx, hx, ly, hy;  // ordered bounds of incoming command
    logic   on_fb;
    logic   take;
    logic   adv;

    // clear means full framebuffer; rect corners may come in any order
    always_comb begin
        if (cmd.op == OP_CLEAR) begin
            lx = '0;
            ly = '0;
            hx = coord_t'(FB_WIDTH - 1);
            hy = coord_t'(FB_HEIGHT - 1);
        end else begin
            lx = (cmd.x0 < cmd.x1) ? cmd.x0 : cmd.x1;
            hx = (cmd.x0 < cmd.x1) ? cmd.x1 : cmd.x0;
            ly = (cmd.y0 < cmd.y1) ? cmd.y0 : cmd.y1;
            hy = (cmd.y0 < cmd.y1) ? cmd.y1 : cmd.y0;
        end
    end

    assign cmd.ready = !active;
    assign on_fb = cx >= 0 && cx < coord_t'(FB_WIDTH)
                && cy >= 0 && cy < coord_t'(FB_HEIGHT);

    assign pix.valid = active && on_fb && (step_en || held);  // held pixel stays up
    assign pix.x     = cx;
    assign pix.y     = cy;
    assign take      = pix.valid && pix.ready;
    assign adv       = take || (active && !on_fb && step_en);  // clipped pixel skipped

    always_ff @(posedge clk_100m or negedge arst_n) begin
        if (!arst_n) begin
            active <= 1'b0;
            held   <= 1'b0;
        end else begin
            if (cmd.valid && cmd.ready) active <= 1'b1;
            else if (adv && cx == bx1 && cy == by1) active <= 1'b0;  // last pixel
            held <= pix.valid && !take;
        end
    end

    always_ff @(posedge clk_100m) begin
        if (cmd.valid && cmd.ready) begin
            cx       <= lx;
            cy       <= ly;
            bx0      <= lx;
            bx1      <= hx;
            by1      <= hy;
            pix.cidx <= (cmd.op == OP_CLEAR) ? '0 : cmd.cidx;
        end else if (adv) begin
            if (cx == bx1) begin  // wrap to next row
                cx <= bx0;
                cy <= cy + 1'b1;
            end else begin
                cx <= cx + 1'b1;
            end
        end
    end

    // framebuffer read priority may stall us; the write must not change
    a_pix_hold: assert property (@(posedge clk_100m) disable iff (!arst_n)
        pix.valid && !pix.ready |=> pix.valid && $stable({pix.x, pix.y, pix.cidx}));

endmodule

// ==== hdl/fb_store.sv ====
// single-port colour index framebuffer
// reads win over writes and return one cycle later
`timescale 1ns/1ps

module fb_store (
    input  logic           clk_100m,
    input  logic           arst_n,
    fb_pix_if.fb           pix,
    input  logic           rd_en,
    input  gfx_pkg::coord_t rd_x,
    input  gfx_pkg::coord_t rd_y,
    output logic           rd_valid,
    output gfx_pkg::cidx_t rd_cidx
);
    import gfx_pkg::*;
    import fb_pkg::*;

    cidx_t    mem [FB_DEPTH];  // row-major colour indices
    fb_addr_t wr_addr;
    fb_addr_t rd_addr;

    assign pix.ready = !rd_en;  // any read blocks the write
    assign wr_addr   = fb_addr(pix.x, pix.y);
    assign rd_addr   = fb_addr(rd_x, rd_y);

    // one port, so one access per cycle
    always_ff @(posedge clk_100m) begin
        if (rd_en) begin
            rd_cidx <= mem[rd_addr];
        end else if (pix.valid) begin
            mem[wr_addr] <= pix.cidx;
        end
    end

    always_ff @(posedge clk_100m or negedge arst_n) begin
        if (!arst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;  // fixed one-cycle latency
        end
    end

    // clipping happens upstream in the rasterizer
    a_wr_in_fb: assert property (@(posedge clk_100m) disable iff (!arst_n)
        pix.valid && pix.ready |-> pix.x >= 0 && pix.x < FB_WIDTH
            && pix.y >= 0 && pix.y < FB_HEIGHT);

endmodule

// ==== hdl/rect_fill_top.sv ====
// filled rectangle drawing subsystem
// sequencer feeds rasterizer, rasterizer writes framebuffer
`timescale 1ns/1ps

module rect_fill_top #(
    parameter int SHAPE_CNT     = 6,
    parameter int FRAME_WAIT    = 2,
    parameter int CYC_PER_FRAME = 64
) (
    input  logic            clk_100m,
    input  logic            arst_n,
    input  logic            frame,     // frame strobe, system clock domain
    input  logic            start,
    input  logic            rd_en,
    input  gfx_pkg::coord_t rd_x,
    input  gfx_pkg::coord_t rd_y,
    output logic            rd_valid,
    output gfx_pkg::cidx_t  rd_cidx,
    output logic            busy,
    output logic            done
);
    draw_cmd_if cmd_bus ();  // sequencer to rasterizer
    fb_pix_if   pix_bus ();  // rasterizer to framebuffer
    logic       step_en;

    rect_scene_seq #(
        .SHAPE_CNT(SHAPE_CNT),
        .FRAME_WAIT(FRAME_WAIT),
        .CYC_PER_FRAME(CYC_PER_FRAME)
    ) seq_inst (
        .clk_100m,
        .arst_n,
        .frame,
        .start,
        .cmd(cmd_bus.seq),
        .step_en,
        .busy,
        .done
    );

    rect_fill_raster raster_inst (
        .clk_100m,
        .arst_n,
        .cmd(cmd_bus.raster),
        .step_en,
        .pix(pix_bus.raster)
    );

    fb_store fb_inst (
        .clk_100m,
        .arst_n,
        .pix(pix_bus.fb),
        .rd_en,
        .rd_x,
        .rd_y,
        .rd_valid,
        .rd_cidx
    );

endmodule

// ==== sim/tb_rect_fill.sv ====
// testbench for the filled rectangle subsystem
// checks the drawn image against a painter's order model, with reads racing the writes
`timescale 1ns/1ps

module tb_rect_fill;

    localparam int SHAPE_CNT     = 6;
    localparam int FRAME_WAIT    = 2;
    localparam int CYC_PER_FRAME = 64;
    localparam int FRAME_CYC     = 200;    // cycles between frame strobes
    localparam int FB_W          = 32;
    localparam int FB_H          = 16;
    localparam int DONE_TIMEOUT  = 30000;  // cycles allowed per scene
    localparam int PROBE_N       = 14;

    logic               clk_100m;
    logic               arst_n;
    logic               frame;
    logic               start;
    logic               rd_en;
    logic signed [15:0] rd_x, rd_y;
    logic               rd_valid;
    logic [3:0]         rd_cidx;
    logic               busy;
    logic               done;

    int          errors;
    int          frame_cnt;         // strobes since time 0
    int          total_pix;         // pixels written per scene, from the model
    int          ref_img [FB_W * FB_H];
    logic [31:0] lfsr;
    logic        rd_en_last;
    logic        hung;              // a scene never reached done

    // probe table: x, y, expected colour index
    logic [15:0] probes [PROBE_N] = '{
        {8'd0,  4'd0,  4'd0},   // background corner
        {8'd2,  4'd1,  4'd1},   // shape 0 top left
        {8'd2,  4'd8,  4'd1},   // shape 0 bottom left, inclusive
        {8'd4,  4'd2,  4'd2},
        {8'd13, 4'd2,  4'd2},
        {8'd7,  4'd3,  4'd3},
        {8'd10, 4'd4,  4'd4},
        {8'd11, 4'd5,  4'd5},
        {8'd12, 4'd8,  4'd6},   // all six overlap, last wins
        {8'd22, 4'd13, 4'd6},   // shape 5 bottom right
        {8'd23, 4'd13, 4'd0},   // one past the right edge
        {8'd18, 4'd3,  4'd0},
        {8'd22, 4'd14, 4'd0},   // one below
        {8'd31, 4'd15, 4'd0}
    };

    rect_fill_top #(
        .SHAPE_CNT(SHAPE_CNT),
        .FRAME_WAIT(FRAME_WAIT),
        .CYC_PER_FRAME(CYC_PER_FRAME)
    ) DUT (
        .clk_100m, .arst_n, .frame, .start,
        .rd_en, .rd_x, .rd_y, .rd_valid, .rd_cidx,
        .busy, .done
    );

    initial begin
        clk_100m = 1'b0;
        forever #5 clk_100m = ~clk_100m;
    end

    // one-cycle strobe every FRAME_CYC cycles
    initial begin
        frame     = 1'b0;
        frame_cnt = 0;
        forever begin
            repeat (FRAME_CYC - 1) @(posedge clk_100m);
            #1;
            frame = 1'b1;
            frame_cnt++;
            @(posedge clk_100m);
            #1;
            frame = 1'b0;
        end
    end

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %0d ns: %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    // read latency is fixed, rd_valid follows rd_en by exactly one edge
    always @(negedge clk_100m) begin
        compare("rd_valid", 32'(rd_en_last), 32'(rd_valid));
        rd_en_last = rd_en;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    // clear to 0, then shapes in order, later over earlier
    task automatic build_model();
        int x0, y0, x1, y1;
        total_pix = FB_W * FB_H;  // the clear
        for (int a = 0; a < FB_W * FB_H; a++) ref_img[a] = 0;
        for (int i = 0; i < SHAPE_CNT; i++) begin
            x0 = 2 + 2 * i;
            y0 = 1 + i;
            x1 = 12 + 2 * i;
            y1 = 8 + i;
            for (int y = y0; y <= y1; y++) begin
                for (int x = x0; x <= x1; x++) begin
                    if (x >= 0 && x < FB_W && y >= 0 && y < FB_H) begin  // clipped
                        ref_img[y * FB_W + x] = i + 1;
                        total_pix++;
                    end
                end
            end
        end
    endtask

    task automatic tick();
        @(posedge clk_100m);
        #1;
    endtask

    task automatic read_pixel(input int x, input int y, output logic [3:0] cidx);
        tick();
        rd_en = 1'b1;
        rd_x  = 16'(x);
        rd_y  = 16'(y);
        tick();
        rd_en = 1'b0;
        compare("rd_valid", 1, 32'(rd_valid));  // never blocked
        cidx = rd_cidx;
    endtask

    task automatic check_image();
        logic [3:0] got;
        int         px, py;
        for (int p = 0; p < PROBE_N; p++) begin
            px = int'(probes[p][15:8]);
            py = int'(probes[p][7:4]);
            read_pixel(px, py, got);
            compare($sformatf("rd_cidx probe (%0d,%0d)", px, py), 32'(probes[p][3:0]), 32'(got));
        end
        for (int y = 0; y < FB_H; y++) begin  // full sweep
            for (int x = 0; x < FB_W; x++) begin
                read_pixel(x, y, got);
                compare($sformatf("rd_cidx (%0d,%0d)", x, y), ref_img[y * FB_W + x], 32'(got));
            end
        end
    endtask

    // start, random reads until done, then pacing and image checks
    task automatic run_scene(input int run_no, output logic timed_out);
        int         f0, frames, cyc, min_frames, rx, ry;
        logic [3:0] dummy;
        timed_out  = 1'b0;
        min_frames = FRAME_WAIT + (total_pix + CYC_PER_FRAME - 1) / CYC_PER_FRAME;
        tick();
        start = 1'b1;
        f0    = frame_cnt;
        tick();
        start = 1'b0;
        compare("busy", 1, 32'(busy));  // one edge after start
        compare("done", 0, 32'(done));
        cyc = 0;
        while (!done && cyc < DONE_TIMEOUT) begin
            if (lfsr_bits(3) == 0) begin  // about one read in eight
                rx = int'(lfsr_bits(5));
                ry = int'(lfsr_bits(4));
                read_pixel(rx, ry, dummy);
                cyc += 2;
            end else begin
                tick();
                cyc++;
            end
        end
        if (!done) begin
            errors++;
            timed_out = 1'b1;
            $display("ERROR: done never rose on run %0d within %0d cycles", run_no, DONE_TIMEOUT);
        end else begin
            frames = frame_cnt - f0;
            compare("busy", 0, 32'(busy));
            if (frames <= FRAME_WAIT) begin
                errors++;
                $display("ERROR: run %0d finished before the frame wait was over", run_no);
            end
            if (frames < min_frames) begin
                errors++;
                $display("ERROR: run %0d took %0d frames, pacing allows no fewer than %0d",
                         run_no, frames, min_frames);
            end
            check_image();
        end
    endtask

    initial begin
        arst_n     = 1'b0;
        start      = 1'b0;
        rd_en      = 1'b0;
        rd_x       = '0;
        rd_y       = '0;
        rd_en_last = 1'b0;
        hung       = 1'b0;
        errors     = 0;
        lfsr       = 32'h1f957959;
        build_model();
        repeat (10) @(posedge clk_100m);
        #1;
        arst_n = 1'b1;
        compare("busy", 0, 32'(busy));
        compare("done", 0, 32'(done));
        compare("rd_valid", 0, 32'(rd_valid));
        run_scene(1, hung);
        if (!hung) begin
            run_scene(2, hung);  // restart from done, clear and redraw
        end
        tick();
        $display("Checks complete with %0d errors", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== src.f ====
hdl/gfx_pkg.sv
hdl/fb_pkg.sv
hdl/draw_cmd_if.sv
hdl/fb_pix_if.sv
hdl/rect_scene_seq.sv
hdl/rect_fill_raster.sv
hdl/fb_store.sv
hdl/rect_fill_top.sv
sim/tb_rect_fill.sv

// ==== Makefile ====
# Verilator build and run of the filled rectangle testbench

SIM  := obj_dir/Vtb_rect_fill
SRCS := $(shell cat src.f)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): src.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_rect_fill -f src.f

# pass or fail comes from the log
run: $(SIM)
	$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
